// ==== s16_video.f ====
hw/s16_video_pkg.sv
hw/s16_cpu_pkg.sv
hw/s16_vtimer.sv
hw/s16_vregs.sv
hw/s16_tilemap.sv
hw/s16_palette.sv
hw/s16_video.sv
test/tb_s16_video.sv

// ==== test/tb_s16_video.sv ====
module tb_s16_video;
    import s16_video_pkg::*;
    import s16_cpu_pkg::*;

    localparam int H_ACT      = 64;
    localparam int H_TOT      = 96;
    localparam int V_ACT      = 32;
    localparam int V_TOT      = 40;
    localparam int CLK_PERIOD = 100;
    localparam int DRV        = 5;
    localparam int LINE_CLKS  = H_TOT * 8;
    localparam int FRAME_CLKS = H_TOT * V_TOT * 8;

    localparam cpu_sel_t SEL_TILE = 3'b100;
    localparam cpu_sel_t SEL_PAL  = 3'b010;
    localparam cpu_sel_t SEL_VREG = 3'b001;

    logic      clk;
    logic      rst_n;
    cpu_bus_t  cpu;
    cpu_sel_t  sel;
    rom_data_t char_data;
    logic      char_ok;
    logic      pxl2_cen;
    logic      pxl_cen;
    logic      HS;
    logic      VS;
    logic      LHBL_dly;
    logic      LVBL_dly;
    rgb5_t     red;
    rgb5_t     green;
    rgb5_t     blue;
    logic      char_cs;
    rom_addr_t char_addr;

    // Reference model state
    logic [15:0] map_m [1024];
    logic [15:0] pal_m [256];
    logic        en_m = 1'b0;
    logic [7:0]  scroll_pend_m = 8'd0;
    logic [7:0]  scroll_m = 8'd0;

    logic [31:0] lfsr = 32'd93;
    int          err_pix = 0;
    int          err_sync = 0;
    int          err_rom = 0;
    int          n_checks = 0;
    int          frame_no = -1;
    int          frames_done = 0;
    int          x_m = 0;
    int          y_m = 0;
    int          act_cnt = 0;
    int          hs_period = 0;
    int          hs_width = 0;
    int          vs_width = 0;
    int          vs_rises = 0;
    int          cen_cnt = 0;
    logic        cen_seen = 1'b0;
    logic        hs_seen = 1'b0;
    logic        hs_last = 1'b0;
    logic        vs_last = 1'b0;
    logic        lhbl_last = 1'b0;
    logic        lvbl_last = 1'b0;

    s16_video #(
        .H_TOTAL  ( H_TOT ),
        .H_ACTIVE ( H_ACT ),
        .HS_START ( 72    ),
        .HS_LEN   ( 8     ),
        .V_TOTAL  ( V_TOT ),
        .V_ACTIVE ( V_ACT ),
        .VS_START ( 34    ),
        .VS_LEN   ( 2     )
    ) dut_i(
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cpu       ( cpu       ),
        .sel       ( sel       ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .char_cs   ( char_cs   ),
        .char_addr ( char_addr )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'hA3000000 : s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Character ROM contents, a fixed hash of the address
    function automatic rom_data_t rom_word(input rom_addr_t a);
        rom_data_t m;
        m = ({20'd0, a} + 32'd7) * 32'h9E3779B1;
        return m ^ (m >> 15);
    endfunction

    // Colour of screen pixel (x, y) as x-R-G-B
    function automatic logic [14:0] expect_rgb(input int x, input int y);
        logic [7:0]  ys;
        logic [4:0]  tx;
        logic [15:0] ent;
        rom_data_t   word;
        logic [3:0]  nib;
        logic [7:0]  idx;
        ys   = 8'(y) + scroll_m;
        tx   = 5'(x / 8);
        ent  = map_m[{ys[7:3], tx}];
        word = rom_word({ent[8:0], ys[2:0]});
        nib  = word[4 * (x % 8) +: 4];
        idx  = (nib == 4'd0) ? 8'd0 : {ent[12:9], nib};
        if (!en_m) return 15'd0;
        return pal_m[idx][14:0];
    endfunction

    task automatic cpu_write(input cpu_sel_t which, input cpu_addr_t addr,
                             input cpu_word_t data, input logic [1:0] dsn);
        @(posedge clk);
        #DRV;
        cpu.addr = addr;
        cpu.din  = data;
        cpu.dsn  = dsn;
        cpu.we   = 1'b1;
        sel      = which;
        @(posedge clk);
        #DRV;
        cpu.we = 1'b0;
        sel    = '0;
        if (which.tile) begin
            if (!dsn[1]) map_m[addr[9:0]][15:8] = data[15:8];
            if (!dsn[0]) map_m[addr[9:0]][7:0] = data[7:0];
        end
        if (which.pal) begin
            if (!dsn[1]) pal_m[addr[7:0]][15:8] = data[15:8];
            if (!dsn[0]) pal_m[addr[7:0]][7:0] = data[7:0];
        end
        if (which.vreg && !dsn[0]) begin
            if (addr[0]) scroll_pend_m = data[7:0];
            else en_m = data[0];
        end
    endtask

    // Pixel enable every 8 clocks, double rate enable every 4 in step
    task automatic check_cen();
        logic exp_1x;
        logic exp_2x;
        if (pxl_cen && !cen_seen) begin
            cen_seen = 1'b1;
            cen_cnt  = 0;
        end
        if (cen_seen) begin
            exp_1x = cen_cnt % 8 == 0;
            exp_2x = cen_cnt % 4 == 0;
            n_checks++;
            if (pxl_cen !== exp_1x) begin
                $display("ERR pxl_cen: expected %h, got %h", exp_1x, pxl_cen);
                err_sync++;
            end
            if (pxl2_cen !== exp_2x) begin
                $display("ERR pxl2_cen: expected %h, got %h", exp_2x, pxl2_cen);
                err_sync++;
            end
            cen_cnt++;
        end
    endtask

    // Pulse widths and spacing, measured in master clocks
    task automatic check_sync();
        hs_period++;
        if (HS) hs_width++;
        if (VS) vs_width++;
        if (HS && !hs_last) begin
            n_checks++;
            if (hs_seen && hs_period != LINE_CLKS) begin
                $display("ERR HS period: expected %h, got %h", LINE_CLKS, hs_period);
                err_sync++;
            end
            hs_seen   = 1'b1;
            hs_period = 0;
        end
        if (!HS && hs_last) begin
            n_checks++;
            if (hs_width != 8 * 8) begin
                $display("ERR HS width: expected %h, got %h", 8 * 8, hs_width);
                err_sync++;
            end
            hs_width = 0;
        end
        if (VS && !vs_last) vs_rises++;
        if (!VS && vs_last) begin
            n_checks++;
            if (vs_width != 2 * LINE_CLKS) begin
                $display("ERR VS width: expected %h, got %h", 2 * LINE_CLKS, vs_width);
                err_sync++;
            end
            vs_width = 0;
        end
        hs_last = HS;
        vs_last = VS;
    endtask

    task automatic check_pixel();
        logic [14:0] exp_c;
        if (LVBL_dly && !lvbl_last) begin
            frame_no++;
            scroll_m = scroll_pend_m;
            if (frame_no > 0 && vs_rises != 1) begin
                $display("ERR VS pulses per frame: expected %h, got %h", 1, vs_rises);
                err_sync++;
            end
            vs_rises = 0;
            act_cnt  = 0;
            y_m      = 0;
        end
        if (!LVBL_dly && lvbl_last) begin
            n_checks++;
            if (act_cnt != H_ACT * V_ACT) begin
                $display("ERR active pixels: expected %h, got %h", H_ACT * V_ACT, act_cnt);
                err_sync++;
            end
            frames_done++;
        end
        if (!LHBL_dly && lhbl_last && LVBL_dly) y_m++;
        if (!LHBL_dly) x_m = 0;
        if (LHBL_dly && LVBL_dly) begin
            exp_c = expect_rgb(x_m, y_m);
            n_checks++;
            if (red !== exp_c[14:10]) begin
                $display("ERR red (%0d,%0d): expected %h, got %h", x_m, y_m, exp_c[14:10], red);
                err_pix++;
            end
            if (green !== exp_c[9:5]) begin
                $display("ERR green (%0d,%0d): expected %h, got %h", x_m, y_m, exp_c[9:5], green);
                err_pix++;
            end
            if (blue !== exp_c[4:0]) begin
                $display("ERR blue (%0d,%0d): expected %h, got %h", x_m, y_m, exp_c[4:0], blue);
                err_pix++;
            end
            act_cnt++;
            x_m++;
        end
        lvbl_last = LVBL_dly;
        lhbl_last = LHBL_dly;
    endtask

    // Outputs are steady at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_cen();
            check_sync();
            if (pxl_cen) check_pixel();
        end
    end

    // Answers each fetch after 1 to 20 clocks
    initial begin : rom_responder
        int        lat;
        int        waited;
        rom_addr_t held;
        char_ok   = 1'b0;
        char_data = '0;
        forever begin
            @(negedge clk);
            if (char_cs) begin
                held = char_addr;
                lat  = 1 + int'(rand_bits(5) % 20);
                repeat (lat) begin
                    @(negedge clk);
                    n_checks++;
                    if (char_addr !== held) begin
                        $display("ERR char_addr: expected %h, got %h", held, char_addr);
                        err_rom++;
                    end
                    if (!char_cs) begin
                        $display("char_cs dropped before the ROM answered");
                        err_rom++;
                    end
                end
                @(posedge clk);
                #DRV;
                char_ok   = 1'b1;
                char_data = rom_word(held);
                waited    = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (char_cs && waited < 3);
                if (char_cs) begin
                    $display("char_cs still high two clocks after char_ok");
                    err_rom++;
                end
                @(posedge clk);
                #DRV;
                char_ok = 1'b0;
            end
        end
    end

    initial begin
        #(8 * FRAME_CLKS * CLK_PERIOD);
        $display("Timeout: the video frames did not complete in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        int         i;
        logic [7:0] idx;
        rst_n = 1'b0;
        cpu   = '0;
        sel   = '0;
        repeat (3) @(posedge clk);
        #DRV;
        rst_n = 1'b1;

        // Frame 0 stays black while the tables fill
        for (i = 0; i < 1024; i++) begin
            cpu_write(SEL_TILE, cpu_addr_t'(i), cpu_word_t'(rand_bits(16)), 2'b00);
        end
        for (i = 0; i < 256; i++) begin
            cpu_write(SEL_PAL, cpu_addr_t'(i), cpu_word_t'(rand_bits(16)), 2'b00);
        end

        wait (frames_done == 1);
        cpu_write(SEL_VREG, 12'd0, 16'h0001, 2'b10);

        // Scroll set in vertical blank shows from frame 2
        wait (frames_done == 2);
        cpu_write(SEL_VREG, 12'd1, cpu_word_t'(rand_bits(8) | 32'h01), 2'b10);

        // Mid-frame scroll must wait for frame 4, and wrap past 255
        wait (frame_no == 3);
        repeat (10) @(posedge HS);
        cpu_write(SEL_VREG, 12'd1, cpu_word_t'(rand_bits(4) | 32'hF0), 2'b10);

        // Single byte lane palette writes
        wait (frames_done == 4);
        for (i = 0; i < 8; i++) begin
            idx = (i < 2) ? 8'd0 : 8'(rand_bits(8));
            cpu_write(SEL_PAL, {4'd0, idx}, cpu_word_t'(rand_bits(16)),
                      i[0] ? 2'b01 : 2'b10);
        end

        wait (frames_done == 5);
        $display("checks %0d, pixel errors %0d, sync errors %0d, rom errors %0d",
                 n_checks, err_pix, err_sync, err_rom);
        if (err_pix + err_sync + err_rom == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== hw/s16_video.sv ====
module s16_video #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int HS_START = 296,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 234,
    parameter int VS_LEN   = 3
)(
    input  logic                     clk,
    input  logic                     rst_n,
    input  s16_cpu_pkg::cpu_bus_t    cpu,
    input  s16_cpu_pkg::cpu_sel_t    sel,
    input  s16_video_pkg::rom_data_t char_data,
    input  logic                     char_ok,
    output logic                     pxl2_cen,   // 4 clocks
    output logic                     pxl_cen,    // 8 clocks
    output logic                     HS,
    output logic                     VS,
    output logic                     LHBL_dly,
    output logic                     LVBL_dly,
    output s16_video_pkg::rgb5_t     red,
    output s16_video_pkg::rgb5_t     green,
    output s16_video_pkg::rgb5_t     blue,
    output logic                     char_cs,
    output s16_video_pkg::rom_addr_t char_addr
);
    import s16_video_pkg::*;

    hpos_t      hdump;
    vpos_t      vdump;
    sync_t      raw_sync;
    video_pix_t pix;
    logic       frame_start;
    logic       video_en;
    logic [7:0] scroll_y;

    s16_vtimer #(
        .H_TOTAL    ( H_TOTAL     ),
        .H_ACTIVE   ( H_ACTIVE    ),
        .HS_START   ( HS_START    ),
        .HS_LEN     ( HS_LEN      ),
        .V_TOTAL    ( V_TOTAL     ),
        .V_ACTIVE   ( V_ACTIVE    ),
        .VS_START   ( VS_START    ),
        .VS_LEN     ( VS_LEN      )
    ) u_vtimer(
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .pxl2_cen   ( pxl2_cen    ),
        .pxl_cen    ( pxl_cen     ),
        .hdump      ( hdump       ),
        .vdump      ( vdump       ),
        .sync       ( raw_sync    ),
        .frame_start( frame_start )
    );

    s16_vregs u_vregs(
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .cpu        ( cpu         ),
        .vreg_cs    ( sel.vreg    ),
        .frame_start( frame_start ),
        .video_en   ( video_en    ),
        .scroll_y   ( scroll_y    )
    );

    s16_tilemap u_tilemap(
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .pxl_cen    ( pxl_cen     ),
        .hdump      ( hdump       ),
        .vdump      ( vdump       ),
        .sync       ( raw_sync    ),
        .scroll_y   ( scroll_y    ),
        .cpu        ( cpu         ),
        .tile_cs    ( sel.tile    ),
        .char_data  ( char_data   ),
        .char_ok    ( char_ok     ),
        .char_cs    ( char_cs     ),
        .char_addr  ( char_addr   ),
        .pix        ( pix         )
    );

    s16_palette u_palette(
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .pxl_cen    ( pxl_cen     ),
        .cpu        ( cpu         ),
        .pal_cs     ( sel.pal     ),
        .video_en   ( video_en    ),
        .pix        ( pix         ),
        .red        ( red         ),
        .green      ( green       ),
        .blue       ( blue        ),
        .LHBL_dly   ( LHBL_dly    ),
        .LVBL_dly   ( LVBL_dly    )
    );

    // Sync leaves through a single register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            HS <= 1'b0;
            VS <= 1'b0;
        end else begin
            HS <= raw_sync.hs;
            VS <= raw_sync.vs;
        end
    end

endmodule

// ==== hw/s16_palette.sv ====
module s16_palette(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  s16_cpu_pkg::cpu_bus_t     cpu,
    input  logic                      pal_cs,
    input  logic                      video_en,
    input  s16_video_pkg::video_pix_t pix,
    output s16_video_pkg::rgb5_t      red,
    output s16_video_pkg::rgb5_t      green,
    output s16_video_pkg::rgb5_t      blue,
    output logic                      LHBL_dly,
    output logic                      LVBL_dly
);
    import s16_cpu_pkg::*;

    // Entry is x-R-G-B, 5 bits per channel
    cpu_word_t pal_ram [256];
    cpu_word_t pal_q;
    logic      show;

    always_ff @(posedge clk) begin
        if (pal_cs && cpu.we) begin
            if (!cpu.dsn[1]) pal_ram[cpu.addr[7:0]][15:8] <= cpu.din[15:8];
            if (!cpu.dsn[0]) pal_ram[cpu.addr[7:0]][7:0]  <= cpu.din[7:0];
        end
        // Index is stable for a whole pixel, so the read settles early
        pal_q <= pal_ram[pix.idx];
    end

    assign show = pix.lhbl && pix.lvbl && video_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (pxl_cen) begin
            LHBL_dly <= pix.lhbl;
            LVBL_dly <= pix.lvbl;
            if (show) begin
                red   <= pal_q[14:10];
                green <= pal_q[9:5];
                blue  <= pal_q[4:0];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

// ==== hw/s16_tilemap.sv ====
module s16_tilemap(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  s16_video_pkg::hpos_t      hdump,
    input  s16_video_pkg::vpos_t      vdump,
    input  s16_video_pkg::sync_t      sync,
    input  logic [7:0]                scroll_y,
    input  s16_cpu_pkg::cpu_bus_t     cpu,
    input  logic                      tile_cs,
    input  s16_video_pkg::rom_data_t  char_data,
    input  logic                      char_ok,
    output logic                      char_cs,
    output s16_video_pkg::rom_addr_t  char_addr,
    output s16_video_pkg::video_pix_t pix
);
    import s16_video_pkg::*;
    import s16_cpu_pkg::*;

    // 32x32 map, code in bits 8-0 and colour in bits 12-9
    cpu_word_t   map_ram [1024];
    cpu_word_t   map_q;
    tile_code_t  map_code;
    logic [3:0]  map_col;
    logic [7:0]  ysum;
    logic [9:0]  map_rd_addr;
    logic [2:0]  tile_row;
    logic        fetch_go;
    fetch_st_e   st;
    logic [3:0]  pend_col;
    rom_data_t   buf_data;
    logic [3:0]  buf_col;
    logic [27:0] shift_data;
    logic [3:0]  shift_col;
    pal_idx_t    pix_idx;
    logic [7:0]  lhbl_sr;
    logic [7:0]  lvbl_sr;

    // Pixel 0 is the backdrop
    function automatic pal_idx_t pix_index(input logic [3:0] col, input logic [3:0] nib);
        return nib == 4'd0 ? pal_idx_t'(0) : {col, nib};
    endfunction

    assign ysum        = vdump[7:0] + scroll_y;
    assign map_rd_addr = {ysum[7:3], hdump[7:3]};
    assign map_code    = map_q[8:0];
    assign map_col     = map_q[12:9];

    // First pixel of each tile in the active area
    assign fetch_go = pxl_cen && hdump[2:0] == 3'd0 && sync.lhbl && sync.lvbl
                      && st == FETCH_IDLE;

    always_ff @(posedge clk) begin
        if (tile_cs && cpu.we) begin
            if (!cpu.dsn[1]) map_ram[cpu.addr[9:0]][15:8] <= cpu.din[15:8];
            if (!cpu.dsn[0]) map_ram[cpu.addr[9:0]][7:0]  <= cpu.din[7:0];
        end
        if (fetch_go) begin
            map_q    <= map_ram[map_rd_addr];
            tile_row <= ysum[2:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st      <= FETCH_IDLE;
            char_cs <= 1'b0;
        end else begin
            case (st)
                FETCH_IDLE: if (fetch_go) st <= FETCH_MAP;
                FETCH_MAP: begin
                    char_cs <= 1'b1;
                    st      <= FETCH_ROM;
                end
                FETCH_ROM: begin
                    // cs drops the cycle after the first ok
                    if (char_ok) begin
                        char_cs <= 1'b0;
                        st      <= FETCH_IDLE;
                    end
                end
                default: st <= FETCH_IDLE;
            endcase
        end
    end

    // Address held steady for the whole ROM access
    always_ff @(posedge clk) begin
        if (st == FETCH_MAP) begin
            char_addr <= {map_code, tile_row};
            pend_col  <= map_col;
        end
        if (st == FETCH_ROM && char_ok) begin
            buf_data <= char_data;
            buf_col  <= pend_col;
        end
    end

    // Shifter reloads at the next tile boundary
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (hdump[2:0] == 3'd7) begin
                pix_idx    <= pix_index(buf_col, buf_data[3:0]);
                shift_data <= buf_data[31:4];
                shift_col  <= buf_col;
            end else begin
                pix_idx    <= pix_index(shift_col, shift_data[3:0]);
                shift_data <= shift_data >> 4;
            end
        end
    end

    // Blanks delayed 8 pixels to stay with their pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_sr <= 8'd0;
            lvbl_sr <= 8'd0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[6:0], sync.lhbl};
            lvbl_sr <= {lvbl_sr[6:0], sync.lvbl};
        end
    end

    always_comb begin
        pix.idx  = pix_idx;
        pix.lhbl = lhbl_sr[7];
        pix.lvbl = lvbl_sr[7];
    end

endmodule

// ==== hw/s16_vregs.sv ====
module s16_vregs(
    input  logic                  clk,
    input  logic                  rst_n,
    input  s16_cpu_pkg::cpu_bus_t cpu,
    input  logic                  vreg_cs,
    input  logic                  frame_start,
    output logic                  video_en,
    output logic [7:0]            scroll_y
);

    logic       low_wr;
    logic [7:0] scroll_pend;

    // Both registers live in the low byte lane
    assign low_wr = vreg_cs && cpu.we && !cpu.dsn[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            video_en    <= 1'b0;
            scroll_pend <= 8'd0;
        end else if (low_wr) begin
            if (cpu.addr[0]) begin
                scroll_pend <= cpu.din[7:0];
            end else begin
                video_en <= cpu.din[0];
            end
        end
    end

    // Scroll takes effect only as a new frame starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scroll_y <= 8'd0;
        end else if (frame_start) begin
            scroll_y <= scroll_pend;
        end
    end

endmodule

// ==== hw/s16_vtimer.sv ====
module s16_vtimer #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int HS_START = 296,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 234,
    parameter int VS_LEN   = 3
)(
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 pxl2_cen,
    output logic                 pxl_cen,
    output s16_video_pkg::hpos_t hdump,
    output s16_video_pkg::vpos_t vdump,
    output s16_video_pkg::sync_t sync,
    output logic                 frame_start
);
    import s16_video_pkg::*;

    logic [2:0] div;
    logic       h_wrap;
    logic       v_last;

    // Master clock divided by 8 for the pixel, by 4 for the double rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div <= 3'd0;
        end else begin
            div <= div + 3'd1;
        end
    end

    assign pxl_cen  = div == 3'd0;
    assign pxl2_cen = div[1:0] == 2'd0;

    assign h_wrap      = pxl_cen && hdump == hpos_t'(H_TOTAL - 1);
    assign v_last      = vdump == vpos_t'(V_TOTAL - 1);
    assign frame_start = h_wrap && v_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else begin
            if (pxl_cen) begin
                hdump <= h_wrap ? hpos_t'(0) : hdump + hpos_t'(1);
            end
            // Line counter steps once per line
            if (h_wrap) begin
                vdump <= v_last ? vpos_t'(0) : vdump + vpos_t'(1);
            end
        end
    end

    // Raw timing decoded straight from the counters
    always_comb begin
        sync.hs   = hdump >= hpos_t'(HS_START) && hdump < hpos_t'(HS_START + HS_LEN);
        sync.vs   = vdump >= vpos_t'(VS_START) && vdump < vpos_t'(VS_START + VS_LEN);
        sync.lhbl = hdump < hpos_t'(H_ACTIVE);
        sync.lvbl = vdump < vpos_t'(V_ACTIVE);
    end

endmodule

// ==== hw/s16_cpu_pkg.sv ====
package s16_cpu_pkg;

    // Word address, CPU address bits 12 to 1
    typedef logic [11:0] cpu_addr_t;

    typedef logic [15:0] cpu_word_t;

    // Write-only bus, dsn bit 1 is the upper byte lane
    typedef struct packed {
        cpu_addr_t  addr;
        cpu_word_t  din;
        logic [1:0] dsn;
        logic       we;
    } cpu_bus_t;

    typedef struct packed {
        logic tile;
        logic pal;
        logic vreg;
    } cpu_sel_t;

endpackage

// ==== hw/s16_video_pkg.sv ====
package s16_video_pkg;

    // Screen position, 9 bits each way
    typedef logic [8:0] hpos_t;
    typedef logic [8:0] vpos_t;

    // Upper nibble is the tile colour, lower nibble the pixel
    typedef logic [7:0] pal_idx_t;

    typedef logic [4:0] rgb5_t;

    typedef logic [8:0] tile_code_t;

    // Tile code followed by the 3-bit row in the tile
    typedef logic [11:0] rom_addr_t;

    // Eight 4-bit pixels, leftmost in the lowest nibble
    typedef logic [31:0] rom_data_t;

    // All active high, blanks are high in the active area
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } sync_t;

    // One pixel with its own blanking
    typedef struct packed {
        pal_idx_t idx;
        logic     lhbl;
        logic     lvbl;
    } video_pix_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_ROM
    } fetch_st_e;

endpackage
